//--- src/turf_pkg.sv
`default_nettype none

package turf_pkg;

  localparam int coord_w = 8; // Widest x, 160 columns
  localparam int row_w   = 7; // Widest y, 120 rows

  typedef logic [2:0] colour_t;
  localparam colour_t BACKGROUND = 3'b111; // White

  typedef logic [1:0] player_t;

  // Blue, green, red, yellow for players 0 to 3
  localparam colour_t [3:0] PLAYER_COLOUR = {3'b110, 3'b100, 3'b010, 3'b001};

  // Matches the low two bits of a turn key
  typedef enum logic [1:0] {
    DIR_UP    = 2'd0,
    DIR_DOWN  = 2'd1,
    DIR_LEFT  = 2'd2,
    DIR_RIGHT = 2'd3
  } dir_t;

  localparam dir_t [3:0] DEFAULT_DIR = {DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT};

  // 0..15 is player*4 + direction, 16 is start
  typedef logic [4:0] key_t;
  localparam key_t KEY_START = 5'd16;

  typedef enum logic {
    OP_PIXEL    = 1'b0,
    OP_GAME_END = 1'b1
  } op_kind_t;

  // {kind, x, y, colour, player_valid, player}
  localparam int OP_W = 1 + coord_w + row_w + 3 + 1 + 2;
  typedef logic [OP_W-1:0] plot_op_t;

  function automatic plot_op_t make_op(op_kind_t kind, logic [coord_w-1:0] x,
                                       logic [row_w-1:0] y, colour_t colour,
                                       logic player_valid, player_t player);
    return {kind, x, y, colour, player_valid, player};
  endfunction

endpackage

`default_nettype wire

//--- src/pipe_slice.sv
`default_nettype none

// One-deep registered stage for a valid/ready link
module pipe_slice #(
  parameter type payload_t = logic
) (
  input  logic     CLOCK_50,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic take;

  // Room when empty or when the held word leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign take     = in_valid && in_ready;

  always_ff @(posedge CLOCK_50)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else if (in_ready)
      out_valid <= in_valid;
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (take)
      out_data <= in_data; // Held under back-pressure
  end

endmodule

`default_nettype wire

//--- src/player_mover.sv
`default_nettype none

module player_mover import turf_pkg::*; #(
  parameter int BOARD_W = 160,
  parameter int BOARD_H = 120
) (
  input  logic               CLOCK_50,
  input  logic               rst_n,
  input  logic               key_valid,
  input  key_t               key_code,
  output logic               key_ready,
  input  logic               frame_step,
  output logic               start_req,
  output logic [coord_w-1:0] p0_x,
  output logic [row_w-1:0]   p0_y,
  output logic [coord_w-1:0] p1_x,
  output logic [row_w-1:0]   p1_y,
  output logic [coord_w-1:0] p2_x,
  output logic [row_w-1:0]   p2_y,
  output logic [coord_w-1:0] p3_x,
  output logic [row_w-1:0]   p3_y
);

  localparam logic [coord_w-1:0] X_MAX = coord_w'(BOARD_W - 1);
  localparam logic [row_w-1:0]   Y_MAX = row_w'(BOARD_H - 1);

  // Start cells one in from each corner, clockwise from top left
  localparam logic [3:0][coord_w-1:0] START_X =
    {coord_w'(1), coord_w'(BOARD_W - 2), coord_w'(BOARD_W - 2), coord_w'(1)};
  localparam logic [3:0][row_w-1:0] START_Y =
    {row_w'(BOARD_H - 2), row_w'(BOARD_H - 2), row_w'(1), row_w'(1)};

  dir_t               dir   [4];
  logic [coord_w-1:0] pos_x [4];
  logic [row_w-1:0]   pos_y [4];
  logic               key_take, is_start, is_turn;

  assign key_ready = 1'b1; // Keys never stall here
  assign key_take  = key_valid && key_ready;
  assign is_start  = key_take && key_code == KEY_START;
  assign is_turn   = key_take && !key_code[4];

  always_ff @(posedge CLOCK_50)
  begin
    if (!rst_n)
    begin
      start_req <= 1'b0;
      for (int i = 0; i < 4; i++)
      begin
        dir[i]   <= DEFAULT_DIR[i];
        pos_x[i] <= START_X[i];
        pos_y[i] <= START_Y[i];
      end
    end
    else
    begin
      start_req <= is_start;
      for (int i = 0; i < 4; i++)
      begin
        if (is_start)
        begin
          dir[i]   <= DEFAULT_DIR[i];
          pos_x[i] <= START_X[i];
          pos_y[i] <= START_Y[i];
        end
        else
        begin
          if (is_turn && key_code[3:2] == player_t'(i))
            dir[i] <= dir_t'(key_code[1:0]);
          if (frame_step) // Old direction is used for this step
            case (dir[i])
              DIR_UP:    pos_y[i] <= (pos_y[i] == '0) ? Y_MAX : pos_y[i] - 1'b1;
              DIR_DOWN:  pos_y[i] <= (pos_y[i] == Y_MAX) ? '0 : pos_y[i] + 1'b1;
              DIR_LEFT:  pos_x[i] <= (pos_x[i] == '0) ? X_MAX : pos_x[i] - 1'b1;
              default:   pos_x[i] <= (pos_x[i] == X_MAX) ? '0 : pos_x[i] + 1'b1;
            endcase
        end
      end
    end
  end

  assign p0_x = pos_x[0];
  assign p0_y = pos_y[0];
  assign p1_x = pos_x[1];
  assign p1_y = pos_y[1];
  assign p2_x = pos_x[2];
  assign p2_y = pos_y[2];
  assign p3_x = pos_x[3];
  assign p3_y = pos_y[3];

endmodule

`default_nettype wire

//--- src/game_sequencer.sv
`default_nettype none

module game_sequencer import turf_pkg::*; #(
  parameter int BOARD_W     = 160,
  parameter int BOARD_H     = 120,
  parameter int GAME_FRAMES = 159
) (
  input  logic               CLOCK_50,
  input  logic               rst_n,
  input  logic               start_req,
  input  logic [coord_w-1:0] p0_x,
  input  logic [row_w-1:0]   p0_y,
  input  logic [coord_w-1:0] p1_x,
  input  logic [row_w-1:0]   p1_y,
  input  logic [coord_w-1:0] p2_x,
  input  logic [row_w-1:0]   p2_y,
  input  logic [coord_w-1:0] p3_x,
  input  logic [row_w-1:0]   p3_y,
  output logic               op_valid,
  output plot_op_t           op_data,
  input  logic               op_ready,
  output logic               frame_step,
  output logic               game_busy
);

  localparam int FRAME_W = $clog2(GAME_FRAMES + 1);
  localparam logic [coord_w-1:0] X_LAST     = coord_w'(BOARD_W - 1);
  localparam logic [row_w-1:0]   Y_LAST     = row_w'(BOARD_H - 1);
  localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(GAME_FRAMES - 1);

  typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_PAINT, S_STEP, S_WAIT, S_FINISH} state_t;

  state_t             state;
  logic [coord_w-1:0] cx;
  logic [row_w-1:0]   cy;
  logic [FRAME_W-1:0] frame;
  player_t            who;   // Player being painted
  logic [coord_w-1:0] px [4];
  logic [row_w-1:0]   py [4];
  logic               op_fire;

  assign px = '{p0_x, p1_x, p2_x, p3_x};
  assign py = '{p0_y, p1_y, p2_y, p3_y};

  always_comb
  begin
    op_valid = 1'b0;
    op_data  = make_op(OP_PIXEL, cx, cy, BACKGROUND, 1'b0, '0); // Clear pixel
    case (state)
      S_CLEAR: op_valid = 1'b1;
      S_PAINT:
      begin
        op_valid = 1'b1;
        op_data  = make_op(OP_PIXEL, px[who], py[who], PLAYER_COLOUR[who], 1'b1, who);
      end
      S_FINISH:
      begin
        op_valid = 1'b1;
        op_data  = make_op(OP_GAME_END, '0, '0, BACKGROUND, 1'b0, '0);
      end
      default: op_valid = 1'b0;
    endcase
  end

  assign op_fire    = op_valid && op_ready;
  assign frame_step = state == S_STEP;
  assign game_busy  = state != S_IDLE;

  always_ff @(posedge CLOCK_50)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      cx    <= '0;
      cy    <= '0;
      frame <= '0;
      who   <= '0;
    end
    else
      case (state)
        S_IDLE:
          if (start_req)
          begin
            state <= S_CLEAR;
            cx    <= '0;
            cy    <= '0;
          end
        S_CLEAR:
          if (op_fire)
          begin
            if (cx == X_LAST)
            begin
              cx <= '0;
              if (cy == Y_LAST)
              begin
                state <= S_PAINT;
                who   <= '0;
                frame <= '0;
              end
              else
                cy <= cy + 1'b1;
            end
            else
              cx <= cx + 1'b1;
          end
        S_PAINT:
          if (op_fire)
          begin
            who <= who + 1'b1; // Wraps back to player 0
            if (who == 2'd3)
              state <= S_STEP;
          end
        S_STEP: state <= S_WAIT; // Mover updates on this edge
        S_WAIT:
          if (frame == FRAME_LAST)
            state <= S_FINISH;
          else
          begin
            frame <= frame + 1'b1;
            state <= S_PAINT;
          end
        S_FINISH:
          if (op_fire)
            state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
  end

endmodule

`default_nettype wire

//--- src/board_store.sv
`default_nettype none

module board_store import turf_pkg::*; #(
  parameter int BOARD_W = 160,
  parameter int BOARD_H = 120
) (
  input  logic               CLOCK_50,
  input  logic               rst_n,
  input  logic               in_valid,
  input  plot_op_t           in_data,
  output logic               in_ready,
  output logic               plot_valid,
  input  logic               plot_ready,
  output logic [coord_w-1:0] plot_x,
  output logic [row_w-1:0]   plot_y,
  output colour_t            plot_colour,
  output logic               tally_start,
  input  logic [coord_w-1:0] rd_x,
  input  logic [row_w-1:0]   rd_y,
  output logic               rd_player_valid,
  output player_t            rd_player
);

  localparam int CELLS  = BOARD_W * BOARD_H;
  localparam int ADDR_W = $clog2(CELLS);

  logic [2:0]         owner_mem [CELLS]; // {valid, player} per cell
  logic               op_kind;
  logic [coord_w-1:0] op_x;
  logic [row_w-1:0]   op_y;
  colour_t            op_colour;
  logic               op_pv;
  player_t            op_player;
  logic               is_end, wr_en;
  logic [ADDR_W-1:0]  wr_addr, rd_addr;

  assign {op_kind, op_x, op_y, op_colour, op_pv, op_player} = in_data;
  assign is_end = op_kind == OP_GAME_END;

  // Game end never reaches the plot port
  assign plot_valid  = in_valid && !is_end;
  assign in_ready    = is_end ? 1'b1 : plot_ready;
  assign plot_x      = op_x;
  assign plot_y      = op_y;
  assign plot_colour = op_colour;

  assign wr_en   = plot_valid && plot_ready;
  assign wr_addr = ADDR_W'(op_y * BOARD_W + op_x);
  assign rd_addr = ADDR_W'(rd_y * BOARD_W + rd_x);

  always_ff @(posedge CLOCK_50)
  begin
    if (wr_en)
      owner_mem[wr_addr] <= {op_pv, op_player}; // Background drops ownership
    {rd_player_valid, rd_player} <= owner_mem[rd_addr];
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (!rst_n)
      tally_start <= 1'b0;
    else
      tally_start <= in_valid && is_end;
  end

endmodule

`default_nettype wire

//--- src/turf_tally.sv
`default_nettype none

module turf_tally import turf_pkg::*; #(
  parameter int BOARD_W = 160,
  parameter int BOARD_H = 120,
  parameter int COUNT_W = 15
) (
  input  logic               CLOCK_50,
  input  logic               rst_n,
  input  logic               tally_start,
  input  logic               game_busy,
  output logic [coord_w-1:0] rd_x,
  output logic [row_w-1:0]   rd_y,
  input  logic               rd_player_valid,
  input  player_t            rd_player,
  output logic               result_valid,
  output player_t            rank_0,
  output player_t            rank_1,
  output player_t            rank_2,
  output player_t            rank_3,
  output logic [COUNT_W-1:0] count_0,
  output logic [COUNT_W-1:0] count_1,
  output logic [COUNT_W-1:0] count_2,
  output logic [COUNT_W-1:0] count_3
);

  localparam logic [coord_w-1:0] X_LAST = coord_w'(BOARD_W - 1);
  localparam logic [row_w-1:0]   Y_LAST = row_w'(BOARD_H - 1);

  typedef enum logic [1:0] {T_IDLE, T_SWEEP, T_DRAIN, T_SORT} state_t;

  state_t             state;
  logic               rd_pend; // Read data valid this cycle
  logic [2:0]         step;
  logic [1:0]         sa;      // Lower slot of current compare-swap
  logic [COUNT_W-1:0] cnt [4];
  player_t            rk  [4];

  // Bubble network (0,1) (1,2) (2,3) (0,1) (1,2) (0,1)
  always_comb
    case (step)
      3'd1, 3'd4: sa = 2'd1;
      3'd2:       sa = 2'd2;
      default:    sa = 2'd0;
    endcase

  always_ff @(posedge CLOCK_50)
  begin
    if (!rst_n)
    begin
      state        <= T_IDLE;
      rd_pend      <= 1'b0;
      result_valid <= 1'b0;
      rd_x         <= '0;
      rd_y         <= '0;
      step         <= '0;
    end
    else
    begin
      rd_pend <= state == T_SWEEP;
      if (game_busy) // New game makes any result stale
      begin
        state        <= T_IDLE;
        result_valid <= 1'b0;
      end
      else
        case (state)
          T_IDLE:
            if (tally_start)
            begin
              state        <= T_SWEEP;
              result_valid <= 1'b0;
              rd_x         <= '0;
              rd_y         <= '0;
            end
          T_SWEEP:
            if (rd_x == X_LAST)
            begin
              rd_x <= '0;
              if (rd_y == Y_LAST)
                state <= T_DRAIN;
              else
                rd_y <= rd_y + 1'b1;
            end
            else
              rd_x <= rd_x + 1'b1;
          T_DRAIN:
          begin
            state <= T_SORT; // Last cell is counted here
            step  <= '0;
          end
          default:
          begin
            step <= step + 1'b1;
            if (step == 3'd5)
            begin
              state        <= T_IDLE;
              result_valid <= 1'b1;
            end
          end
        endcase
    end
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (state == T_IDLE && tally_start)
      for (int i = 0; i < 4; i++)
      begin
        cnt[i] <= '0;
        rk[i]  <= player_t'(i);
      end
    else if (rd_pend && rd_player_valid)
      cnt[rd_player] <= cnt[rd_player] + 1'b1;
    else if (state == T_SORT && cnt[rk[sa+1]] > cnt[rk[sa]]) // Ties keep lower index
    begin
      rk[sa]   <= rk[sa+1];
      rk[sa+1] <= rk[sa];
    end
  end

  assign rank_0  = rk[0];
  assign rank_1  = rk[1];
  assign rank_2  = rk[2];
  assign rank_3  = rk[3];
  assign count_0 = cnt[0];
  assign count_1 = cnt[1];
  assign count_2 = cnt[2];
  assign count_3 = cnt[3];

endmodule

`default_nettype wire

//--- src/turf_wars_top.sv
`default_nettype none

module turf_wars_top import turf_pkg::*; #(
  parameter int BOARD_W     = 160,
  parameter int BOARD_H     = 120,
  parameter int GAME_FRAMES = 159,
  parameter int COUNT_W     = 15
) (
  input  logic               CLOCK_50,
  input  logic               rst_n,
  input  logic               key_valid,
  output logic               key_ready,
  input  key_t               key_code,
  output logic               plot_valid,
  input  logic               plot_ready,
  output logic [coord_w-1:0] plot_x,
  output logic [row_w-1:0]   plot_y,
  output colour_t            plot_colour,
  output logic               result_valid,
  output player_t            rank_0,
  output player_t            rank_1,
  output player_t            rank_2,
  output player_t            rank_3,
  output logic [COUNT_W-1:0] count_0,
  output logic [COUNT_W-1:0] count_1,
  output logic [COUNT_W-1:0] count_2,
  output logic [COUNT_W-1:0] count_3
);

  logic               mk_valid, mk_ready; // Key slice to mover
  key_t               mk_code;
  logic               start_req, frame_step, game_busy;
  logic [coord_w-1:0] p0_x, p1_x, p2_x, p3_x;
  logic [row_w-1:0]   p0_y, p1_y, p2_y, p3_y;
  logic               sq_valid, sq_ready; // Sequencer to plot slice
  plot_op_t           sq_data;
  logic               bs_valid, bs_ready; // Plot slice to board store
  plot_op_t           bs_data;
  logic               tally_start;
  logic [coord_w-1:0] rd_x;
  logic [row_w-1:0]   rd_y;
  logic               rd_player_valid;
  player_t            rd_player;

  pipe_slice #(.payload_t(key_t)) u_key_slice (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n),
    .in_valid(key_valid), .in_data(key_code), .in_ready(key_ready),
    .out_valid(mk_valid), .out_data(mk_code), .out_ready(mk_ready)
  );

  player_mover #(.BOARD_W(BOARD_W), .BOARD_H(BOARD_H)) u_mover (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n),
    .key_valid(mk_valid), .key_code(mk_code), .key_ready(mk_ready),
    .frame_step(frame_step), .start_req(start_req),
    .p0_x(p0_x), .p0_y(p0_y), .p1_x(p1_x), .p1_y(p1_y),
    .p2_x(p2_x), .p2_y(p2_y), .p3_x(p3_x), .p3_y(p3_y)
  );

  game_sequencer #(
    .BOARD_W(BOARD_W), .BOARD_H(BOARD_H), .GAME_FRAMES(GAME_FRAMES)
  ) u_sequencer (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n), .start_req(start_req),
    .p0_x(p0_x), .p0_y(p0_y), .p1_x(p1_x), .p1_y(p1_y),
    .p2_x(p2_x), .p2_y(p2_y), .p3_x(p3_x), .p3_y(p3_y),
    .op_valid(sq_valid), .op_data(sq_data), .op_ready(sq_ready),
    .frame_step(frame_step), .game_busy(game_busy)
  );

  pipe_slice #(.payload_t(plot_op_t)) u_plot_slice (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n),
    .in_valid(sq_valid), .in_data(sq_data), .in_ready(sq_ready),
    .out_valid(bs_valid), .out_data(bs_data), .out_ready(bs_ready)
  );

  board_store #(.BOARD_W(BOARD_W), .BOARD_H(BOARD_H)) u_store (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n),
    .in_valid(bs_valid), .in_data(bs_data), .in_ready(bs_ready),
    .plot_valid(plot_valid), .plot_ready(plot_ready),
    .plot_x(plot_x), .plot_y(plot_y), .plot_colour(plot_colour),
    .tally_start(tally_start), .rd_x(rd_x), .rd_y(rd_y),
    .rd_player_valid(rd_player_valid), .rd_player(rd_player)
  );

  turf_tally #(.BOARD_W(BOARD_W), .BOARD_H(BOARD_H), .COUNT_W(COUNT_W)) u_tally (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n),
    .tally_start(tally_start), .game_busy(game_busy),
    .rd_x(rd_x), .rd_y(rd_y),
    .rd_player_valid(rd_player_valid), .rd_player(rd_player),
    .result_valid(result_valid),
    .rank_0(rank_0), .rank_1(rank_1), .rank_2(rank_2), .rank_3(rank_3),
    .count_0(count_0), .count_1(count_1), .count_2(count_2), .count_3(count_3)
  );

endmodule

`default_nettype wire

//--- sim/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// One row per game with the keys sent before start, an optional turn key at a frame,
// the plot_ready stall percentage and hand-worked counts and ranks
// A count or rank of -1 is left to the model
localparam int NUM_CASES = 5;
localparam int MAX_PRE   = 4;

string case_name [NUM_CASES];
int    pre_n     [NUM_CASES];
key_t  pre_key   [NUM_CASES][MAX_PRE];
logic  mid_en    [NUM_CASES];
key_t  mid_key   [NUM_CASES];
int    mid_frame [NUM_CASES];
int    stall_pct [NUM_CASES];
int    want_cnt  [NUM_CASES][4];
int    want_rank [NUM_CASES][4];

task automatic load_cases();
  // Default paths on 12x10 over 20 frames give 5, 5, 10, 10
  case_name[0] = "default paths, tie";
  pre_n[0]     = 0;
  pre_key[0]   = '{5'd0, 5'd0, 5'd0, 5'd0};
  mid_en[0]    = 1'b0;
  mid_key[0]   = 5'd0;
  mid_frame[0] = 0;
  stall_pct[0] = 0;
  want_cnt[0]  = '{5, 5, 10, 10};
  want_rank[0] = '{2, 3, 0, 1};

  // Turns before start are undone by the start key
  // Codes 20 and 31 do nothing
  case_name[1] = "keys before start";
  pre_n[1]     = 4;
  pre_key[1]   = '{5'd1, 5'd20, 5'd14, 5'd31};
  mid_en[1]    = 1'b0;
  mid_key[1]   = 5'd0;
  mid_frame[1] = 0;
  stall_pct[1] = 60;
  want_cnt[1]  = '{5, 5, 10, 10};
  want_rank[1] = '{2, 3, 0, 1};

  case_name[2] = "p2 turns left";
  pre_n[2]     = 0;
  pre_key[2]   = '{5'd0, 5'd0, 5'd0, 5'd0};
  mid_en[2]    = 1'b1;
  mid_key[2]   = 5'd10;
  mid_frame[2] = 5;
  stall_pct[2] = 0;
  want_cnt[2]  = '{-1, -1, -1, -1};
  want_rank[2] = '{-1, -1, -1, -1};

  case_name[3] = "p0 turns up";
  pre_n[3]     = 1;
  pre_key[3]   = '{5'd17, 5'd0, 5'd0, 5'd0};
  mid_en[3]    = 1'b1;
  mid_key[3]   = 5'd0;
  mid_frame[3] = 3;
  stall_pct[3] = 60;
  want_cnt[3]  = '{-1, -1, -1, -1};
  want_rank[3] = '{-1, -1, -1, -1};

  case_name[4] = "p1 turns down late";
  pre_n[4]     = 0;
  pre_key[4]   = '{5'd0, 5'd0, 5'd0, 5'd0};
  mid_en[4]    = 1'b1;
  mid_key[4]   = 5'd5;
  mid_frame[4] = 12;
  stall_pct[4] = 60;
  want_cnt[4]  = '{-1, -1, -1, -1};
  want_rank[4] = '{-1, -1, -1, -1};
endtask

`endif

//--- sim/tb_turf_wars.sv
`default_nettype none

module tb_turf_wars import turf_pkg::*; ();

  localparam int BOARD_W     = 12;
  localparam int BOARD_H     = 10;
  localparam int GAME_FRAMES = 20;
  localparam int COUNT_W     = 15;
  localparam int CELLS       = BOARD_W * BOARD_H;
  localparam int CLK_PERIOD  = 4;
  localparam int CASE_TIME   = (CELLS + 5 * GAME_FRAMES + CELLS + 64) * 8 * CLK_PERIOD;

  logic               CLOCK_50, rst_n;
  logic               key_valid, key_ready;
  key_t               key_code;
  logic               plot_valid, plot_ready;
  logic [coord_w-1:0] plot_x;
  logic [row_w-1:0]   plot_y;
  colour_t            plot_colour;
  logic               result_valid;
  player_t            rank_0, rank_1, rank_2, rank_3;
  logic [COUNT_W-1:0] count_0, count_1, count_2, count_3;

  `include "tb_cases.svh"

  int exp_x [$]; // Expected plot stream
  int exp_y [$];
  int exp_c [$];
  int exp_cnt  [4];
  int exp_rank [4];
  int checks, failures, case_fail, cur_case;

  turf_wars_top #(
    .BOARD_W(BOARD_W), .BOARD_H(BOARD_H), .GAME_FRAMES(GAME_FRAMES), .COUNT_W(COUNT_W)
  ) dut (
    .CLOCK_50(CLOCK_50), .rst_n(rst_n),
    .key_valid(key_valid), .key_ready(key_ready), .key_code(key_code),
    .plot_valid(plot_valid), .plot_ready(plot_ready),
    .plot_x(plot_x), .plot_y(plot_y), .plot_colour(plot_colour),
    .result_valid(result_valid),
    .rank_0(rank_0), .rank_1(rank_1), .rank_2(rank_2), .rank_3(rank_3),
    .count_0(count_0), .count_1(count_1), .count_2(count_2), .count_3(count_3)
  );

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
  end

  task automatic check_value(input string sig, input logic [31:0] want,
                             input logic [31:0] got);
    checks++;
    assert (got === want) else
    begin
      $display("[FAIL] %s expected 0x%0h got 0x%0h in case %0d", sig, want, got, cur_case);
      failures++;
      case_fail++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else
    begin
      $display("ERROR: %s in case %0d", what, cur_case);
      failures++;
      case_fail++;
    end
  endtask

  // Corners inset by one in clockwise order from top left
  function automatic int start_x(int p);
    return (p == 0 || p == 3) ? 1 : BOARD_W - 2;
  endfunction

  function automatic int start_y(int p);
    return (p < 2) ? 1 : BOARD_H - 2;
  endfunction

  function automatic int start_dir(int p);
    case (p)
      0:       return int'(DIR_RIGHT);
      1:       return int'(DIR_LEFT);
      2:       return int'(DIR_DOWN);
      default: return int'(DIR_UP);
    endcase
  endfunction

  task automatic step_player(inout int x, inout int y, input int d);
    case (d)
      int'(DIR_UP):   y = (y + BOARD_H - 1) % BOARD_H;
      int'(DIR_DOWN): y = (y + 1) % BOARD_H;
      int'(DIR_LEFT): x = (x + BOARD_W - 1) % BOARD_W;
      default:        x = (x + 1) % BOARD_W;
    endcase
  endtask

  // Reference game with plot stream, final owners, counts and ranking
  task automatic build_model(input int c);
    int px [4];
    int py [4];
    int pd [4];
    int owner [CELLS];
    int best;
    bit used [4];
    exp_x.delete();
    exp_y.delete();
    exp_c.delete();
    for (int p = 0; p < 4; p++)
    begin
      px[p] = start_x(p); // Start key undoes any earlier turn
      py[p] = start_y(p);
      pd[p] = start_dir(p);
    end
    for (int a = 0; a < CELLS; a++)
    begin
      owner[a] = -1;
      exp_x.push_back(a % BOARD_W);
      exp_y.push_back(a / BOARD_W);
      exp_c.push_back(int'(BACKGROUND));
    end
    for (int f = 0; f < GAME_FRAMES; f++)
    begin
      for (int p = 0; p < 4; p++)
      begin
        exp_x.push_back(px[p]);
        exp_y.push_back(py[p]);
        exp_c.push_back(int'(PLAYER_COLOUR[p]));
        owner[py[p] * BOARD_W + px[p]] = p; // Later write wins
      end
      if (mid_en[c] && f == mid_frame[c])
        pd[mid_key[c] / 4] = mid_key[c] % 4;
      for (int p = 0; p < 4; p++)
        step_player(px[p], py[p], pd[p]);
    end
    exp_cnt = '{0, 0, 0, 0};
    for (int a = 0; a < CELLS; a++)
      if (owner[a] >= 0)
        exp_cnt[owner[a]]++;
    used = '{0, 0, 0, 0};
    for (int r = 0; r < 4; r++)
    begin
      best = -1;
      for (int p = 0; p < 4; p++)
        if (!used[p] && (best < 0 || exp_cnt[p] > exp_cnt[best]))
          best = p; // Strict compare keeps ties on the lower index
      used[best] = 1'b1;
      exp_rank[r] = best;
    end
  endtask

  task automatic send_key(input key_t code);
    @(negedge CLOCK_50);
    check_true(key_ready, "key port was not ready for a key");
    check_true(!plot_valid, "a plot appeared before the start key");
    key_valid = 1'b1;
    key_code  = code;
    @(negedge CLOCK_50);
    key_valid = 1'b0;
  endtask

  task automatic run_case(input int c);
    int          idx;
    bit          mid_sent;
    bit          first_plot;
    bit          extra_seen;
    logic [31:0] got_cnt  [4];
    logic [31:0] got_rank [4];
    build_model(c);
    for (int k = 0; k < pre_n[c]; k++)
      send_key(pre_key[c][k]);
    send_key(KEY_START);
    idx        = 0;
    mid_sent   = 1'b0;
    first_plot = 1'b1;
    while (idx < exp_x.size())
    begin
      @(negedge CLOCK_50);
      key_valid  = 1'b0;
      plot_ready = ($urandom_range(99) >= stall_pct[c]);
      if (plot_valid)
      begin
        if (first_plot)
          check_value("result_valid", 0, result_valid); // Old result dropped
        first_plot = 1'b0;
        // Turn lands while player 0 of the frame is on the plot port
        if (mid_en[c] && !mid_sent && idx == CELLS + 4 * mid_frame[c])
        begin
          check_true(key_ready, "key port was not ready for the mid-game key");
          key_valid = 1'b1;
          key_code  = mid_key[c];
          mid_sent  = 1'b1;
        end
        if (plot_ready)
        begin
          check_value($sformatf("plot_x[%0d]", idx), exp_x[idx], plot_x);
          check_value($sformatf("plot_y[%0d]", idx), exp_y[idx], plot_y);
          check_value($sformatf("plot_colour[%0d]", idx), exp_c[idx], plot_colour);
          idx++;
        end
      end
    end
    extra_seen = 1'b0;
    while (!result_valid)
    begin
      @(negedge CLOCK_50);
      key_valid  = 1'b0;
      plot_ready = ($urandom_range(99) >= stall_pct[c]);
      if (plot_valid && !extra_seen)
      begin
        check_true(1'b0, "a plot came after the last game pixel");
        extra_seen = 1'b1;
      end
    end
    got_cnt  = '{count_0, count_1, count_2, count_3};
    got_rank = '{rank_0, rank_1, rank_2, rank_3};
    for (int i = 0; i < 4; i++)
    begin
      check_value($sformatf("count_%0d", i), exp_cnt[i], got_cnt[i]);
      check_value($sformatf("rank_%0d", i), exp_rank[i], got_rank[i]);
      if (want_cnt[c][i] >= 0)
        check_value($sformatf("count_%0d", i), want_cnt[c][i], got_cnt[i]);
      if (want_rank[c][i] >= 0)
        check_value($sformatf("rank_%0d", i), want_rank[c][i], got_rank[i]);
    end
  endtask

  initial
  begin
    rst_n      = 1'b0;
    key_valid  = 1'b0;
    key_code   = '0;
    plot_ready = 1'b0;
    checks     = 0;
    failures   = 0;
    case_fail  = 0;
    cur_case   = -1;
    void'($urandom(32'h7fbb_6634));
    load_cases();
    repeat (8) @(negedge CLOCK_50);
    rst_n = 1'b1;
    repeat (10) // Nothing plotted while idle after reset
    begin
      @(negedge CLOCK_50);
      check_value("plot_valid", 0, plot_valid);
      check_value("result_valid", 0, result_valid);
      check_value("key_ready", 1, key_ready);
    end
    for (int c = 0; c < NUM_CASES; c++)
    begin
      cur_case  = c;
      case_fail = 0;
      run_case(c);
      $display("case %0d  %s, stall %0d%%: %0d failures",
               c, case_name[c], stall_pct[c], case_fail);
    end
    $display("cases %0d, checks %0d, failures %0d", NUM_CASES, checks, failures);
    if (failures == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(NUM_CASES * CASE_TIME);
    $display("ERROR: watchdog expired after %0d time units, the run stalled",
             NUM_CASES * CASE_TIME);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
src/turf_pkg.sv
src/pipe_slice.sv
src/player_mover.sv
src/game_sequencer.sv
src/board_store.sv
src/turf_tally.sv
src/turf_wars_top.sv
sim/tb_turf_wars.sv

//--- Bender.yml
package:
  name: turf_wars

sources:
  - src/turf_pkg.sv
  - src/pipe_slice.sv
  - src/player_mover.sv
  - src/game_sequencer.sv
  - src/board_store.sv
  - src/turf_tally.sv
  - src/turf_wars_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_turf_wars.sv
